/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_uart_multi
FILELIST  ?= src.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) design/uart_macros.svh

.PHONY: run clean

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/bus_pkg.sv */
`default_nettype none

// Word types of the register bus
package bus_pkg;

    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

endpackage

`default_nettype wire

/* design/uart_macros.svh */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Address map of the transmit block
`define UART_BASE        32'h1000_0000
`define UART_CH_STRIDE   32'h0000_0010 // One channel spans four words

// Channel count and index width, kept in step by hand
`define UART_NUM_CH      4
`define UART_CH_BITS     2

// 115200 baud from a 50 MHz clock
`define UART_DEFAULT_BAUD 16'd434

`endif

/* design/uart_multi_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "uart_macros.svh"

module uart_multi_top (
    input  logic                    clk,
    input  logic                    rst,
    input  bus_pkg::bus_addr_t      addr,
    input  bus_pkg::bus_data_t      write_data,
    input  logic                    write_enable,
    input  logic                    read_enable,
    output bus_pkg::bus_data_t      read_data,
    output logic                    addr_hit,
    output logic [`UART_NUM_CH-1:0] tx
);

    import bus_pkg::*;
    import uart_pkg::*;

    logic [`UART_CH_BITS-1:0] ch_sel;
    uart_reg_e                reg_sel;
    logic [`UART_NUM_CH-1:0]  byte_valid;
    logic [`UART_NUM_CH-1:0]  ctrl_wr;
    logic [`UART_NUM_CH-1:0]  baud_wr;
    bus_data_t                ch_data    [`UART_NUM_CH];
    bus_data_t                ch_status  [`UART_NUM_CH];
    bus_data_t                ch_control [`UART_NUM_CH];
    bus_data_t                ch_baud    [`UART_NUM_CH];

    uart_reg_decode i_decode (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .write_enable (write_enable),
        .read_enable  (read_enable),
        .addr_hit     (addr_hit),
        .ch_sel       (ch_sel),
        .reg_sel      (reg_sel),
        .byte_valid   (byte_valid),
        .ctrl_wr      (ctrl_wr),
        .baud_wr      (baud_wr)
    );

    // Ready stays inside each channel, the decoder does not wait on it
    for (genvar i = 0; i < `UART_NUM_CH; i++) begin : g_ch
        uart_tx_channel i_channel (
            .clk         (clk),
            .rst         (rst),
            .write_data  (write_data),
            .byte_valid  (byte_valid[i]),
            .ctrl_wr     (ctrl_wr[i]),
            .baud_wr     (baud_wr[i]),
            .byte_ready  (),
            .reg_data    (ch_data[i]),
            .reg_status  (ch_status[i]),
            .reg_control (ch_control[i]),
            .reg_baud    (ch_baud[i]),
            .tx          (tx[i])
        );
    end

    uart_read_mux i_read_mux (
        .read_enable (read_enable),
        .addr_hit    (addr_hit),
        .ch_sel      (ch_sel),
        .reg_sel     (reg_sel),
        .ch_data     (ch_data),
        .ch_status   (ch_status),
        .ch_control  (ch_control),
        .ch_baud     (ch_baud),
        .read_data   (read_data)
    );

endmodule

`default_nettype wire

/* design/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // Register offset inside a channel, taken from addr[3:2]
    typedef enum logic [1:0] {
        REG_DATA    = 2'd0, // 0x0
        REG_STATUS  = 2'd1, // 0x4
        REG_CONTROL = 2'd2, // 0x8
        REG_BAUD    = 2'd3  // 0xC
    } uart_reg_e;

    typedef logic [15:0] baud_div_t;

    // Frame sequencer states
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_e;

endpackage

`default_nettype wire

/* design/uart_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none
`include "uart_macros.svh"

module uart_read_mux (
    input  logic                     read_enable,
    input  logic                     addr_hit,
    input  logic [`UART_CH_BITS-1:0] ch_sel,
    input  uart_pkg::uart_reg_e      reg_sel,
    input  bus_pkg::bus_data_t       ch_data    [`UART_NUM_CH],
    input  bus_pkg::bus_data_t       ch_status  [`UART_NUM_CH],
    input  bus_pkg::bus_data_t       ch_control [`UART_NUM_CH],
    input  bus_pkg::bus_data_t       ch_baud    [`UART_NUM_CH],
    output bus_pkg::bus_data_t       read_data
);

    import bus_pkg::*;
    import uart_pkg::*;

    bus_data_t reg_word [`UART_NUM_CH]; // Addressed register of each channel

    always_comb begin
        for (int i = 0; i < `UART_NUM_CH; i++) begin
            case (reg_sel)
                REG_DATA:    reg_word[i] = ch_data[i];
                REG_STATUS:  reg_word[i] = ch_status[i];
                REG_CONTROL: reg_word[i] = ch_control[i];
                REG_BAUD:    reg_word[i] = ch_baud[i];
                default:     reg_word[i] = '0;
            endcase
        end
    end

    // Zero unless a read lands inside the window
    assign read_data = (read_enable && addr_hit) ? reg_word[ch_sel] : '0;

endmodule

`default_nettype wire

/* design/uart_reg_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "uart_macros.svh"

module uart_reg_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  bus_pkg::bus_addr_t        addr,
    input  logic                      write_enable,
    input  logic                      read_enable,
    output logic                      addr_hit,
    output logic [`UART_CH_BITS-1:0]  ch_sel,
    output uart_pkg::uart_reg_e       reg_sel,
    output logic [`UART_NUM_CH-1:0]   byte_valid,
    output logic [`UART_NUM_CH-1:0]   ctrl_wr,
    output logic [`UART_NUM_CH-1:0]   baud_wr
);

    import bus_pkg::*;
    import uart_pkg::*;

    localparam bus_addr_t WINDOW = `UART_NUM_CH * `UART_CH_STRIDE;

    bus_addr_t offset;
    logic      wr_hit;

    assign offset   = addr - `UART_BASE;
    assign addr_hit = (addr >= `UART_BASE) && (offset < WINDOW);

    // Stride of 16 bytes puts the channel index right above the word offset
    assign ch_sel  = offset[`UART_CH_BITS+3:4];
    assign reg_sel = uart_reg_e'(addr[3:2]);

    assign wr_hit = write_enable && addr_hit;

    always_comb begin
        byte_valid = '0;
        ctrl_wr    = '0;
        baud_wr    = '0;
        if (wr_hit) begin
            case (reg_sel)
                REG_DATA:    byte_valid[ch_sel] = 1'b1;
                REG_CONTROL: ctrl_wr[ch_sel]    = 1'b1;
                REG_BAUD:    baud_wr[ch_sel]    = 1'b1;
                default: ; // STATUS is read only
            endcase
        end
    end

    // One write strobe at most, across every channel and register
    strobe_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({byte_valid, ctrl_wr, baud_wr})
    ) else $error("more than one register write strobe active");

    // The bus never reads and writes the window in the same cycle
    no_rd_wr_overlap: assert property (
        @(posedge clk) disable iff (rst)
        addr_hit |-> !(read_enable && write_enable)
    ) else $error("read and write to the transmit window in one cycle");

endmodule

`default_nettype wire

/* design/uart_tx_channel.sv */
`timescale 1ns/1ps
`default_nettype none
`include "uart_macros.svh"

module uart_tx_channel (
    input  logic               clk,
    input  logic               rst,
    input  bus_pkg::bus_data_t write_data,
    input  logic               byte_valid,
    input  logic               ctrl_wr,
    input  logic               baud_wr,
    output logic               byte_ready,
    output bus_pkg::bus_data_t reg_data,
    output bus_pkg::bus_data_t reg_status,
    output bus_pkg::bus_data_t reg_control,
    output bus_pkg::bus_data_t reg_baud,
    output logic               tx
);

    import uart_pkg::*;

    logic [7:0] tx_data;
    logic       tx_enable;
    baud_div_t  baud_div;
    baud_div_t  baud_counter;
    logic       baud_reload;  // Counter picks up a new divisor next cycle
    logic       baud_tick;
    logic       busy;
    logic       empty;
    logic       overrun;      // Sticky until the frame ends
    logic       start_pending;
    tx_state_e  tx_state;
    logic [2:0] bit_cnt;
    logic       tx_out;

    assign byte_ready = !busy && tx_enable;
    assign baud_tick  = (baud_counter == '0) && !baud_reload;
    assign tx         = tx_out;

    // Divisor and enable registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_enable   <= 1'b1;
            baud_div    <= `UART_DEFAULT_BAUD;
            baud_reload <= 1'b0;
        end else begin
            baud_reload <= baud_wr;
            if (ctrl_wr)
                tx_enable <= write_data[0];
            if (baud_wr)
                baud_div <= write_data[15:0];
        end
    end

    // Down-counter, one tick every baud_div+1 cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            baud_counter <= `UART_DEFAULT_BAUD;
        else if (baud_reload || baud_tick)
            baud_counter <= baud_div;
        else
            baud_counter <= baud_counter - 1'b1;
    end

    // Byte buffer, flags and frame sequencer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_data       <= 8'h00;
            busy          <= 1'b0;
            empty         <= 1'b1;
            overrun       <= 1'b0;
            start_pending <= 1'b0;
            tx_state      <= TX_IDLE;
            bit_cnt       <= 3'd0;
            tx_out        <= 1'b1;
        end else begin
            if (byte_valid && byte_ready) begin
                tx_data       <= write_data[7:0];
                busy          <= 1'b1; // Visible before the start bit
                empty         <= 1'b0;
                start_pending <= 1'b1;
            end else if (byte_valid) begin
                overrun <= 1'b1;       // Byte lost
            end

            if (baud_tick) begin
                case (tx_state)
                    TX_IDLE: begin
                        if (start_pending) begin
                            tx_state      <= TX_START;
                            tx_out        <= 1'b0;
                            start_pending <= 1'b0;
                        end
                    end
                    TX_START: begin
                        tx_state <= TX_DATA;
                        tx_out   <= tx_data[0]; // LSB first
                        bit_cnt  <= 3'd0;
                    end
                    TX_DATA: begin
                        if (bit_cnt == 3'd7) begin
                            tx_state <= TX_STOP;
                            tx_out   <= 1'b1;
                        end else begin
                            tx_out  <= tx_data[bit_cnt + 3'd1];
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                    TX_STOP: begin
                        tx_state <= TX_IDLE;
                        busy     <= 1'b0;
                        empty    <= 1'b1;
                        overrun  <= 1'b0;
                    end
                    default: tx_state <= TX_IDLE;
                endcase
            end
        end
    end

    assign reg_data    = {24'h0, tx_data};
    assign reg_status  = {29'h0, busy, empty, overrun};
    assign reg_control = {31'h0, tx_enable};
    assign reg_baud    = {16'h0, baud_div};

    idle_line_high: assert property (
        @(posedge clk) disable iff (rst)
        (tx_state == TX_IDLE) |-> tx
    ) else $error("tx low while the sequencer is idle");

    // Busy has to cover every state of the frame
    no_ready_when_busy: assert property (
        @(posedge clk) disable iff (rst)
        (tx_state != TX_IDLE) |-> !byte_ready
    ) else $error("byte_ready high during a frame");

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/bus_pkg.sv
design/uart_pkg.sv
design/uart_reg_decode.sv
design/uart_tx_channel.sv
design/uart_read_mux.sv
design/uart_multi_top.sv
tests/tb_uart_multi.sv

/* tests/tb_uart_multi.sv */
`timescale 1ns/1ps
`default_nettype none
`include "uart_macros.svh"

module tb_uart_multi;

    localparam int DATA_OFF    = 'h0;
    localparam int STATUS_OFF  = 'h4;
    localparam int CONTROL_OFF = 'h8;
    localparam int BAUD_OFF    = 'hC;
    localparam logic [31:0] PAST_END = `UART_BASE + `UART_NUM_CH * `UART_CH_STRIDE;

    logic                    clk;
    logic                    rst;
    logic [31:0]             addr;
    logic [31:0]             write_data;
    logic                    write_enable;
    logic                    read_enable;
    logic [31:0]             read_data;
    logic                    addr_hit;
    logic [`UART_NUM_CH-1:0] tx;
    int                      test_err = 0;
    int                      pass_cnt = 0;
    int                      fail_cnt = 0;
    int                      exp_baud [`UART_NUM_CH]; // Divisor last written per channel

    uart_multi_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] reg_addr(input int ch, input int off);
        return `UART_BASE + ch * `UART_CH_STRIDE + off;
    endfunction

    // Bus tasks start and end 2 ns after a rising edge
    task automatic write_reg(input logic [31:0] a, input logic [31:0] data);
        addr         = a;
        write_data   = data;
        write_enable = 1'b1;
        @(posedge clk);
        #2 write_enable = 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] a, output logic [31:0] data, output logic hit);
        addr        = a;
        read_enable = 1'b1;
        #10;
        data = read_data; // Combinational read, settled well before the edge
        hit  = addr_hit;
        @(posedge clk);
        #2 read_enable = 1'b0;
    endtask

    task automatic expect_word(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            test_err++;
        end
    endtask

    task automatic check_reg(input int ch, input int off, input logic [31:0] exp);
        logic [31:0] data;
        logic        hit;
        read_reg(reg_addr(ch, off), data, hit);
        expect_word($sformatf("ch%0d addr_hit at 0x%0h", ch, off), hit, 1'b1);
        expect_word($sformatf("ch%0d register 0x%0h", ch, off), data, exp);
    endtask

    task automatic set_baud(input int ch, input int div);
        write_reg(reg_addr(ch, BAUD_OFF), div);
        exp_baud[ch] = div;
    endtask

    task automatic align_to_bus();
        @(posedge clk);
        #2;
    endtask

    // tx is sampled on falling clock edges, away from the DUT updates
    task automatic wait_start(input int ch, input int max_cycles, output bit found);
        int n = 0;
        found = 1'b0;
        while (!found && n < max_cycles) begin
            @(negedge clk);
            found = !tx[ch];
            n++;
        end
    endtask

    task automatic receive_byte(input int ch, input int div, output logic [7:0] data);
        bit found;
        data = 8'h00;
        wait_start(ch, 3 * (div + 1) + 8, found);
        if (!found) begin
            $display("timeout: channel %0d sent no start bit", ch);
            test_err++;
        end else begin
            repeat (div / 2) @(negedge clk); // Middle of the start bit
            assert (!tx[ch]) else begin
                $display("error at %0t ns: channel %0d start bit did not stay low",
                         $time, ch);
                test_err++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (div + 1) @(negedge clk);
                data[i] = tx[ch]; // LSB first
            end
            repeat (div + 1) @(negedge clk);
            assert (tx[ch]) else begin
                $display("error at %0t ns: channel %0d stop bit was low", $time, ch);
                test_err++;
            end
        end
        align_to_bus();
    endtask

    task automatic expect_no_frame(input int ch, input int cycles);
        bit found;
        wait_start(ch, cycles, found);
        assert (!found) else begin
            $display("error at %0t ns: channel %0d sent a frame for a dropped byte",
                     $time, ch);
            test_err++;
        end
        align_to_bus();
    endtask

    // Polls STATUS until busy drops
    task automatic wait_idle(input int ch);
        logic [31:0] status;
        logic        hit;
        int          n = 0;
        status = 32'h4;
        while (status[2] && n < 12 * (exp_baud[ch] + 1)) begin
            read_reg(reg_addr(ch, STATUS_OFF), status, hit);
            n++;
        end
        if (status[2]) begin
            $display("timeout: channel %0d stayed busy after its frame", ch);
            test_err++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_err == 0) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, test_err);
        end
        test_err = 0;
    endtask

    initial begin
        int          fd;
        string       line;
        int          ch;
        int          div;
        int          value;
        int          pat_ch[$];
        int          pat_div[$];
        int          pat_byte[$];
        logic [7:0]  got [`UART_NUM_CH];
        logic [7:0]  multi_byte [`UART_NUM_CH];
        logic [31:0] data;
        logic        hit;

        rst          = 1'b1;
        addr         = '0;
        write_data   = '0;
        write_enable = 1'b0;
        read_enable  = 1'b0;
        void'($urandom(58));
        foreach (exp_baud[i])
            exp_baud[i] = `UART_DEFAULT_BAUD;
        multi_byte = '{8'hA5, 8'h3C, 8'h0F, 8'hE1};

        fd = $fopen("tests/uart_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/uart_patterns.txt");
            fail_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "%h %h %h", ch, div, value) == 3) begin // Skips comments
                    pat_ch.push_back(ch);
                    pat_div.push_back(div);
                    pat_byte.push_back(value);
                end
            end
            $fclose(fd);
        end

        repeat (10) @(posedge clk);
        #2 rst = 1'b0;

        for (int c = 0; c < `UART_NUM_CH; c++) begin
            check_reg(c, DATA_OFF, 32'h0);
            check_reg(c, STATUS_OFF, 32'h2);
            check_reg(c, CONTROL_OFF, 32'h1);
            check_reg(c, BAUD_OFF, `UART_DEFAULT_BAUD);
        end
        expect_word("tx lines", tx, {`UART_NUM_CH{1'b1}});
        finish_test("1 reset values");

        assert (pat_ch.size() > 0) else begin
            $display("the pattern file held no transmissions");
            test_err++;
        end
        foreach (pat_ch[i]) begin
            set_baud(pat_ch[i], pat_div[i]);
            fork
                receive_byte(pat_ch[i], pat_div[i], got[0]);
                begin
                    write_reg(reg_addr(pat_ch[i], DATA_OFF), pat_byte[i]);
                    check_reg(pat_ch[i], STATUS_OFF, 32'h4); // Busy only
                end
            join
            expect_word($sformatf("pattern %0d byte", i), got[0], pat_byte[i]);
            wait_idle(pat_ch[i]);
            check_reg(pat_ch[i], STATUS_OFF, 32'h2);
            repeat ($urandom_range(5)) align_to_bus();
        end
        finish_test("2 pattern frames");

        set_baud(1, 4);
        fork
            receive_byte(1, 4, got[1]);
            begin
                write_reg(reg_addr(1, DATA_OFF), 32'h5A);
                write_reg(reg_addr(1, DATA_OFF), 32'hC3); // Lands while busy
                check_reg(1, STATUS_OFF, 32'h5);
            end
        join
        expect_word("byte sent before overrun", got[1], 8'h5A);
        check_reg(1, DATA_OFF, 32'h5A);
        wait_idle(1);
        check_reg(1, STATUS_OFF, 32'h2);
        expect_no_frame(1, 20 * 5);
        finish_test("3 back-to-back overrun");

        set_baud(2, 3);
        write_reg(reg_addr(2, CONTROL_OFF), 32'h0);
        write_reg(reg_addr(2, DATA_OFF), 32'h77);
        check_reg(2, STATUS_OFF, 32'h3); // Empty and overrun
        expect_no_frame(2, 20 * 4);
        write_reg(reg_addr(2, CONTROL_OFF), 32'h1);
        fork
            receive_byte(2, 3, got[2]);
            write_reg(reg_addr(2, DATA_OFF), 32'h96);
        join
        expect_word("byte after enable", got[2], 8'h96);
        wait_idle(2);
        check_reg(2, STATUS_OFF, 32'h2);
        finish_test("4 disabled channel");

        for (int c = 0; c < `UART_NUM_CH; c++)
            set_baud(c, 3 + 2 * c);
        fork
            receive_byte(0, 3, got[0]);
            receive_byte(1, 5, got[1]);
            receive_byte(2, 7, got[2]);
            receive_byte(3, 9, got[3]);
            for (int c = 0; c < `UART_NUM_CH; c++)
                write_reg(reg_addr(c, DATA_OFF), multi_byte[c]);
        join
        for (int c = 0; c < `UART_NUM_CH; c++) begin
            expect_word($sformatf("ch%0d parallel byte", c), got[c], multi_byte[c]);
            wait_idle(c);
        end
        finish_test("5 parallel channels");

        read_reg(PAST_END, data, hit);
        expect_word("addr_hit above window", hit, 1'b0);
        expect_word("read_data above window", data, 32'h0);
        read_reg(`UART_BASE - 32'h4, data, hit);
        expect_word("addr_hit below window", hit, 1'b0);
        expect_word("read_data below window", data, 32'h0);
        write_reg(PAST_END + CONTROL_OFF, 32'h0);
        write_reg(PAST_END + BAUD_OFF, 32'h55);
        write_reg(`UART_BASE - 32'h10 + DATA_OFF, 32'hFF);
        for (int c = 0; c < `UART_NUM_CH; c++) begin
            check_reg(c, CONTROL_OFF, 32'h1);
            check_reg(c, BAUD_OFF, exp_baud[c]);
            check_reg(c, STATUS_OFF, 32'h2);
        end
        expect_word("tx lines", tx, {`UART_NUM_CH{1'b1}});
        finish_test("6 outside window");

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/uart_patterns.txt */
# channel  baud_div  byte, all in hex
# The decoded byte on tx must equal the written byte
0 3 55
1 5 a3
2 2 00
3 7 ff
0 a 81
1 4 3c
2 6 e7
3 e 18
